// ==== source/dsp16_ctrl_pkg.sv ====
package dsp16_ctrl_pkg;

    // Program word and its fields
    typedef logic [15:0] word_t;
    typedef logic [4:0]  t_field_t;    // Opcode field, bits 15 to 11
    typedef logic [2:0]  reg_field_t;
    typedef logic [1:0]  acc_field_t;
    typedef logic [8:0]  short_imm_t;

    // Default loop counter widths
    localparam int K_W  = 7;           // Iteration count
    localparam int NI_W = 4;           // Instruction count

    // goto B subcode for return from interrupt
    localparam logic [2:0] IRET_CODE = 3'd1;

    // Instruction classes by T field
    // Some classes occupy a pair of T codes. The decoder folds the
    // second code of each pair onto the name below before the case
    typedef enum t_field_t {
        goto_ja   = 5'd0,      // Also 1
        short_imm = 5'd2,      // Also 3, j k rb re
        f1_plain  = 5'd6,      // F1 with Y read
        f1_y      = 5'd7,      // F1, aT=Y
        r_from_a  = 5'd9,      // R=a0, R=a1 on 11
        long_imm  = 5'd10,
        do_redo   = 5'd14,
        ram_move  = 5'd15,     // R=Y, Y=R on 12
        call_ja   = 5'd16,     // Also 17
        goto_b    = 5'd24,     // return, iret, goto pt, call pt
        if_con    = 5'd26
    } opcode_e;

endpackage

// ==== source/loop_if.sv ====
// Loop set-up from the decoder and loop status back from the sequencer
interface loop_if #(
    parameter int K_W  = dsp16_ctrl_pkg::K_W,
    parameter int NI_W = dsp16_ctrl_pkg::NI_W
);

    logic            cnt_ld;   // One cycle after a do/redo word
    logic            redo;
    logic            short_do; // do with a single instruction body
    logic [NI_W-1:0] ni;       // Index of the last body instruction
    logic [K_W-1:0]  k;
    logic            double;   // Second half of a two-cycle word

    logic            busy;
    logic            stretch;

    modport decoder (
        output cnt_ld, redo, short_do, ni, k, double,
        input  busy, stretch
    );

    modport sequencer (
        input  cnt_ld, redo, short_do, ni, k, double,
        output busy, stretch
    );

endinterface

// ==== source/insn_decoder.sv ====
module insn_decoder #(
    parameter int K_W  = dsp16_ctrl_pkg::K_W,
    parameter int NI_W = dsp16_ctrl_pkg::NI_W
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        cen,
    input  dsp16_ctrl_pkg::word_t       rom_dout,
    input  logic                        con_result,
    input  logic                        irq_take,
    output logic                        iret,
    loop_if.decoder                     loop,
    output logic                        goto_ja,
    output logic                        call_ja,
    output logic                        goto_b,
    output logic                        pc_halt,
    output logic                        con_check,
    output logic                        short_load,
    output logic                        long_load,
    output logic                        acc_load,
    output logic                        ram_load,
    output logic                        ram_we,
    output logic                        post_load,
    output logic                        dau_dec_en,
    output dsp16_ctrl_pkg::reg_field_t  r_field,
    output dsp16_ctrl_pkg::reg_field_t  rsel,
    output dsp16_ctrl_pkg::acc_field_t  a_field,
    output logic [1:0]                  y_mod,
    output dsp16_ctrl_pkg::short_imm_t  short_imm,
    output logic                        irq_start,
    output logic                        do_redo,
    output logic                        do_save,
    output logic                        fault
);

    dsp16_ctrl_pkg::t_field_t t;
    dsp16_ctrl_pkg::opcode_e  op;
    logic                     double_q;
    logic                     redo_q;
    logic                     con_ok;
    logic                     is_iret;

    assign t           = rom_dout[15:11];
    assign con_ok      = !con_check || con_result; // No pending if CON means always
    assign is_iret     = rom_dout[10:8] == dsp16_ctrl_pkg::IRET_CODE;
    assign loop.double = double_q;
    assign loop.redo   = redo_q;
    assign do_redo     = redo_q;

    // Fold paired T codes onto one class
    always_comb begin
        case (t)
            5'd1, 5'd3, 5'd17: op = dsp16_ctrl_pkg::opcode_e'({t[4:1], 1'b0});
            5'd11:             op = dsp16_ctrl_pkg::r_from_a;
            5'd12:             op = dsp16_ctrl_pkg::ram_move;
            default:           op = dsp16_ctrl_pkg::opcode_e'(t);
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            {goto_ja, call_ja, goto_b, pc_halt, con_check} <= '0;
            {short_load, long_load, acc_load, ram_load, ram_we} <= '0;
            {post_load, dau_dec_en, irq_start, do_save, iret} <= '0;
            fault         <= 1'b0;
            double_q      <= 1'b0;
            redo_q        <= 1'b0;
            loop.cnt_ld   <= 1'b0;
            loop.short_do <= 1'b0;
            loop.ni       <= '0;
            loop.k        <= '0;
        end else if (cen) begin
            {goto_ja, call_ja, goto_b, pc_halt, con_check} <= '0;
            {short_load, long_load, acc_load, ram_load, ram_we} <= '0;
            {post_load, dau_dec_en, irq_start, do_save, iret} <= '0;
            double_q    <= 1'b0;
            loop.cnt_ld <= 1'b0;

            if (!double_q) begin
                if (irq_take) begin
                    // Interrupt replaces the current word
                    goto_ja   <= 1'b1;
                    irq_start <= 1'b1;
                    pc_halt   <= 1'b1;
                    double_q  <= 1'b1;
                end else begin
                    case (op)
                        dsp16_ctrl_pkg::goto_ja: begin
                            goto_ja  <= con_ok;
                            pc_halt  <= 1'b1;
                            double_q <= 1'b1;
                            if (loop.busy) fault <= 1'b1; // No jumps out of a loop
                        end
                        dsp16_ctrl_pkg::call_ja: begin
                            call_ja  <= con_ok;
                            pc_halt  <= 1'b1;
                            double_q <= 1'b1;
                            if (loop.busy) fault <= 1'b1;
                        end
                        dsp16_ctrl_pkg::goto_b: begin
                            goto_b   <= con_ok || is_iret; // iret ignores the condition
                            iret     <= is_iret;
                            pc_halt  <= 1'b1;
                            double_q <= 1'b1;
                            if (loop.busy) fault <= 1'b1;
                        end
                        dsp16_ctrl_pkg::short_imm: short_load <= 1'b1;
                        dsp16_ctrl_pkg::r_from_a: begin
                            acc_load <= rom_dout[8:7] == 2'b00; // YAAU destination only
                            pc_halt  <= 1'b1;
                            double_q <= 1'b1;
                        end
                        dsp16_ctrl_pkg::long_imm: begin
                            // Immediate follows as the next word
                            long_load <= rom_dout[9:7] == 3'b000;
                            double_q  <= 1'b1;
                            if (loop.busy) fault <= 1'b1;
                        end
                        dsp16_ctrl_pkg::ram_move: begin
                            ram_load  <= rom_dout[10:7] == 4'b0000 && t == 5'd15;
                            ram_we    <= t == 5'd12;
                            post_load <= 1'b1;
                            pc_halt   <= 1'b1;
                            double_q  <= 1'b1;
                        end
                        dsp16_ctrl_pkg::f1_plain: dau_dec_en <= 1'b1;
                        dsp16_ctrl_pkg::f1_y: begin
                            dau_dec_en <= 1'b1;
                            post_load  <= 1'b1;
                        end
                        dsp16_ctrl_pkg::if_con: con_check <= !rom_dout[10];
                        dsp16_ctrl_pkg::do_redo: begin
                            loop.cnt_ld <= 1'b1;
                            if (rom_dout[10:7] == 4'd0) begin
                                // Replay of the cached body
                                redo_q        <= 1'b1;
                                loop.short_do <= 1'b0;
                                loop.k        <= K_W'(rom_dout[6:0]);
                                pc_halt       <= 1'b1;
                                double_q      <= 1'b1;
                            end else begin
                                redo_q  <= 1'b0;
                                do_save <= 1'b1;
                                loop.ni <= NI_W'(rom_dout[10:7] - 4'd1);
                                // Single word body has its first pass stretched at once
                                if (rom_dout[10:7] == 4'd1) begin
                                    loop.short_do <= 1'b1;
                                    loop.k        <= K_W'(rom_dout[6:0] - 7'd1);
                                end else begin
                                    loop.short_do <= 1'b0;
                                    loop.k        <= K_W'(rom_dout[6:0]);
                                end
                            end
                        end
                        default: fault <= 1'b1; // Unknown T field
                    endcase
                end
            end

            if (loop.stretch) begin
                pc_halt  <= 1'b1;
                double_q <= 1'b1;
                if (redo_q) redo_q <= 1'b0; // Stretch during redo is the exit
            end
        end
    end

    // Register fields of decoded words
    always_ff @(posedge clk) begin
        if (cen && !double_q && !irq_take) begin
            short_imm <= rom_dout[8:0];
            y_mod     <= rom_dout[1:0];
            a_field   <= '0;
            case (op)
                dsp16_ctrl_pkg::short_imm: r_field <= rom_dout[11:9] ^ 3'b100;
                dsp16_ctrl_pkg::r_from_a: begin
                    r_field <= rom_dout[6:4];
                    a_field <= {1'b1, rom_dout[12]};
                end
                dsp16_ctrl_pkg::long_imm: r_field <= rom_dout[6:4];
                dsp16_ctrl_pkg::ram_move: begin
                    r_field <= rom_dout[6:4];
                    rsel    <= rom_dout[8:6];
                end
                dsp16_ctrl_pkg::f1_plain, dsp16_ctrl_pkg::f1_y: a_field <= rom_dout[10:9];
                default: ;
            endcase
        end
    end

    branch_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0({goto_ja, call_ja, goto_b}));

endmodule

// ==== source/do_loop_seq.sv ====
module do_loop_seq #(
    parameter int K_W  = dsp16_ctrl_pkg::K_W,
    parameter int NI_W = dsp16_ctrl_pkg::NI_W
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            cen,
    loop_if.sequencer       loop,
    output logic            do_start,
    output logic            do_out,
    output logic [NI_W-1:0] do_pc
);

    logic [NI_W-1:0] ni_cnt;
    logic [K_W-1:0]  k_cnt;
    logic            first_done;
    logic            done_eff;
    logic            over;
    logic            first_loop;

    assign over      = ni_cnt == loop.ni;   // Last instruction of a pass
    assign loop.busy = k_cnt != '0;
    assign done_eff  = first_done && !loop.cnt_ld; // Flag is stale until the load edge

    // Last word of the first pass, or the sole word of a short do
    assign first_loop = ((over && k_cnt == loop.k && loop.busy) || loop.short_do)
                        && !done_eff;

    assign do_out       = loop.busy && over && k_cnt == K_W'(1) && !loop.double;
    assign do_start     = (!loop.redo && first_loop) || (loop.redo && !loop.busy);
    assign loop.stretch = (first_loop && !loop.redo) || do_out;
    assign do_pc        = ni_cnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ni_cnt <= '0;
            k_cnt  <= '0;
        end else if (cen) begin
            if (loop.cnt_ld) begin
                // Cached body and single word body start at index 0
                ni_cnt <= (loop.redo || loop.short_do) ? '0 : NI_W'(1);
                k_cnt  <= loop.k;
            end else if (!loop.double) begin
                ni_cnt <= over ? '0 : ni_cnt + NI_W'(1);
                if (over && loop.busy) k_cnt <= k_cnt - K_W'(1);
            end
        end
    end

    // First pass stretch happens once per do word
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            first_done <= 1'b0;
        end else if (cen) begin
            if (loop.stretch) begin
                first_done <= 1'b1;
            end else if (loop.cnt_ld) begin
                first_done <= 1'b0;
            end
        end
    end

    // A new loop may only be loaded once the previous one has ended
    load_idle: assert property (@(posedge clk) disable iff (rst)
        loop.cnt_ld |-> !loop.busy);

endmodule

// ==== source/irq_entry.sv ====
module irq_entry (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     cen,
    input  logic                     irq,
    input  dsp16_ctrl_pkg::t_field_t t_field,
    input  logic                     busy,
    input  logic                     double,
    input  logic                     iret,
    output logic                     take,
    output logic                     iack
);

    logic int_ok;
    logic clr_pend;

    // Branches, do and if CON must not be split from what follows
    always_comb begin
        case (t_field)
            5'd0, 5'd1, 5'd14, 5'd16, 5'd17, 5'd24, 5'd26: int_ok = 1'b0;
            default:                                       int_ok = 1'b1;
        endcase
    end

    assign take = irq && int_ok && !busy && !iack && !double;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            iack     <= 1'b0;
            clr_pend <= 1'b0;
        end else if (cen) begin
            if (take) begin
                iack     <= 1'b1;
                clr_pend <= 1'b0;
            end else if (iret || clr_pend) begin
                if (int_ok && !double) begin
                    iack     <= 1'b0;   // Interrupts open again
                    clr_pend <= 1'b0;
                end else begin
                    clr_pend <= 1'b1;
                end
            end
        end
    end

    // The interrupt branch is two-cycle, so entry cannot repeat at once
    single_entry: assert property (@(posedge clk) disable iff (rst)
        (cen && take) |=> (iack && !take));

endmodule

// ==== source/dsp16_ctrl.sv ====
module dsp16_ctrl #(
    parameter int K_W  = dsp16_ctrl_pkg::K_W,
    parameter int NI_W = dsp16_ctrl_pkg::NI_W
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        cen,
    input  dsp16_ctrl_pkg::word_t       rom_dout,
    input  logic                        irq,
    input  logic                        con_result,
    output logic                        goto_ja,
    output logic                        call_ja,
    output logic                        goto_b,
    output logic                        pc_halt,
    output logic                        con_check,
    output logic                        short_load,
    output logic                        long_load,
    output logic                        acc_load,
    output logic                        ram_load,
    output logic                        ram_we,
    output logic                        post_load,
    output logic                        dau_dec_en,
    output dsp16_ctrl_pkg::reg_field_t  r_field,
    output dsp16_ctrl_pkg::reg_field_t  rsel,
    output dsp16_ctrl_pkg::acc_field_t  a_field,
    output logic [1:0]                  y_mod,
    output dsp16_ctrl_pkg::short_imm_t  short_imm,
    output dsp16_ctrl_pkg::word_t       long_imm,
    output logic                        irq_start,
    output logic                        iack,
    output logic                        do_start,
    output logic                        do_out,
    output logic                        do_redo,
    output logic                        do_save,
    output logic [NI_W-1:0]             do_pc,
    output logic                        fault
);

    logic irq_take;
    logic iret;

    loop_if #(.K_W(K_W), .NI_W(NI_W)) loop_bus ();

    assign long_imm = rom_dout;   // Long immediate is the word after the load

    insn_decoder #(.K_W(K_W), .NI_W(NI_W)) u_decoder (
        .clk, .rst, .cen, .rom_dout, .con_result, .irq_take, .iret,
        .loop       (loop_bus.decoder),
        .goto_ja, .call_ja, .goto_b, .pc_halt, .con_check,
        .short_load, .long_load, .acc_load, .ram_load, .ram_we,
        .post_load, .dau_dec_en, .r_field, .rsel, .a_field, .y_mod,
        .short_imm, .irq_start, .do_redo, .do_save, .fault
    );

    do_loop_seq #(.K_W(K_W), .NI_W(NI_W)) u_loop (
        .clk, .rst, .cen,
        .loop       (loop_bus.sequencer),
        .do_start, .do_out, .do_pc
    );

    irq_entry u_irq (
        .clk, .rst, .cen, .irq,
        .t_field    (rom_dout[15:11]),
        .busy       (loop_bus.busy),
        .double     (loop_bus.double),
        .iret,
        .take       (irq_take),
        .iack
    );

endmodule

// ==== tb/ctrl_ref_model.svh ====
`ifndef CTRL_REF_MODEL_SVH
`define CTRL_REF_MODEL_SVH

// Strobe vector bits, high to low
// goto_ja call_ja goto_b pc_halt con_check short_load long_load
// acc_load ram_load ram_we post_load dau_dec_en
function automatic dsp16_ctrl_pkg::word_t expect_decode(dsp16_ctrl_pkg::word_t w,
        logic con_pend, logic con_res, logic dbl);
    dsp16_ctrl_pkg::word_t s;
    logic go;
    s  = '0;
    go = !con_pend || con_res;  // Branch runs unless a false if CON precedes it
    if (!dbl) begin
        case (w[15:11])
            5'd0, 5'd1:   begin s[11] = go; s[8] = 1'b1; end
            5'd16, 5'd17: begin s[10] = go; s[8] = 1'b1; end
            5'd24:        begin s[9] = go || (w[10:8] == 3'd1); s[8] = 1'b1; end
            5'd2, 5'd3:   s[6] = 1'b1;
            5'd9, 5'd11:  begin s[4] = (w[8:7] == 2'b00); s[8] = 1'b1; end
            5'd10:        s[5] = (w[9:7] == 3'b000);
            5'd15:        begin s[3] = (w[10:7] == 4'd0); s[1] = 1'b1; s[8] = 1'b1; end
            5'd12:        begin s[2] = 1'b1; s[1] = 1'b1; s[8] = 1'b1; end
            5'd6:         s[0] = 1'b1;
            5'd7:         begin s[0] = 1'b1; s[1] = 1'b1; end
            5'd26:        s[7] = !w[10];
            5'd14:        s[8] = (w[10:7] == 4'd0);   // Only redo halts the PC
            default:      ;
        endcase
    end
    return s;
endfunction

function automatic logic two_cycle(dsp16_ctrl_pkg::word_t w);
    case (w[15:11])
        5'd0, 5'd1, 5'd9, 5'd10, 5'd11, 5'd12, 5'd15, 5'd16, 5'd17, 5'd24: return 1'b1;
        5'd14:   return w[10:7] == 4'd0;
        default: return 1'b0;
    endcase
endfunction

function automatic logic has_r_field(dsp16_ctrl_pkg::word_t w);
    case (w[15:11])
        5'd2, 5'd3, 5'd9, 5'd10, 5'd11, 5'd12, 5'd15: return 1'b1;
        default: return 1'b0;
    endcase
endfunction

function automatic dsp16_ctrl_pkg::reg_field_t expect_r_field(dsp16_ctrl_pkg::word_t w);
    if (w[15:12] == 4'b0001)
        return {~w[11], w[10:9]};   // Short immediate register code
    return w[6:4];
endfunction

function automatic dsp16_ctrl_pkg::acc_field_t expect_a_field(dsp16_ctrl_pkg::word_t w);
    case (w[15:11])
        5'd9, 5'd11: return {1'b1, w[12]};
        5'd6, 5'd7:  return w[10:9];
        default:     return 2'b00;
    endcase
endfunction

// Cycle of do_out counted from the do or redo word. A do body starts one
// cycle later and gains one stretched cycle after pass one, a redo starts
// two cycles later, so both land on K*NI+1
function automatic int expect_loop(int ni, int k);
    return k * ni + 1;
endfunction

`endif

// ==== tb/tb_dsp16_ctrl.sv ====
module tb_dsp16_ctrl;

    localparam int MAX_LOOP    = 10 * 8 + 4;
    localparam int TOTAL_WORDS = 220 + 4 * MAX_LOOP;
    localparam dsp16_ctrl_pkg::word_t F1 = {5'd6, 11'h000};

    logic clk, rst, cen, irq, con_result;
    dsp16_ctrl_pkg::word_t rom_dout, long_imm;
    logic goto_ja, call_ja, goto_b, pc_halt, con_check, short_load, long_load, acc_load;
    logic ram_load, ram_we, post_load, dau_dec_en, irq_start, iack;
    logic do_start, do_out, do_redo, do_save, fault;
    dsp16_ctrl_pkg::reg_field_t r_field, rsel;
    dsp16_ctrl_pkg::acc_field_t a_field;
    logic [1:0] y_mod;
    dsp16_ctrl_pkg::short_imm_t short_imm;
    logic [3:0] do_pc;

    dsp16_ctrl_pkg::word_t act_strobes, act_fields, act_status;
    dsp16_ctrl_pkg::word_t exp_strobes, exp_word;
    logic chk_en, fld_en, exp_take, exp_iack, exp_fault, dbl, con_pend;
    int errors, ntests;

    dsp16_ctrl UUT (.*);

    `include "ctrl_ref_model.svh"

    assign act_strobes = {4'b0, goto_ja, call_ja, goto_b, pc_halt, con_check, short_load,
                          long_load, acc_load, ram_load, ram_we, post_load, dau_dec_en};
    assign act_fields  = {6'b0, r_field, rsel, a_field, y_mod};
    assign act_status  = {5'b0, irq_start, iack, do_start, do_out, do_redo, do_save, fault,
                          do_pc};

    always #4 clk = ~clk;

    task automatic check_word(string name, dsp16_ctrl_pkg::word_t e, dsp16_ctrl_pkg::word_t a);
        if (a !== e) begin
            errors++;
            $display("FAILED %s: expected %h, got %h", name, e, a);
        end
    endtask

    task automatic check_reg(string name, dsp16_ctrl_pkg::reg_field_t e,
            dsp16_ctrl_pkg::reg_field_t a);
        if (a !== e) begin
            errors++;
            $display("FAILED %s: expected %h, got %h", name, e, a);
        end
    endtask

    task automatic check_acc(string name, dsp16_ctrl_pkg::acc_field_t e,
            dsp16_ctrl_pkg::acc_field_t a);
        if (a !== e) begin
            errors++;
            $display("FAILED %s: expected %h, got %h", name, e, a);
        end
    endtask

    task automatic check_bit(string name, logic e, logic a);
        if (a !== e) begin
            errors++;
            $display("FAILED %s: expected %h, got %h", name, e, a);
        end
    endtask

    // Compares registered outputs just after each enabled edge
    always @(posedge clk) begin
        if (chk_en) begin
            #1;
            check_word("strobes", exp_strobes, act_strobes);
            check_word("long_imm", exp_word, long_imm);
            check_bit("irq_start", exp_take, irq_start);
            check_bit("iack", exp_iack, iack);
            check_bit("fault", exp_fault, fault);
            if (fld_en) begin
                if (has_r_field(exp_word))
                    check_reg("r_field", expect_r_field(exp_word), r_field);
                if (exp_word[15:11] == 5'd12 || exp_word[15:11] == 5'd15)
                    check_reg("rsel", exp_word[8:6], rsel);
                check_acc("a_field", expect_a_field(exp_word), a_field);
                check_acc("y_mod", exp_word[1:0], y_mod);
                check_word("short_imm", 16'(exp_word[8:0]), 16'(short_imm));
            end
        end
    end

    task automatic issue(dsp16_ctrl_pkg::word_t w, logic c, logic irq_v, logic take,
            logic iack_next);
        @(negedge clk);
        rom_dout   = w;
        con_result = c;
        irq        = irq_v;
        if (take) begin
            exp_strobes = 16'h0900;   // goto_ja and pc_halt
            fld_en      = 1'b0;
            con_pend    = 1'b0;
            dbl         = 1'b1;
        end else begin
            exp_strobes = expect_decode(w, con_pend, c, dbl);
            fld_en      = !dbl;
            con_pend    = exp_strobes[7];
            dbl         = !dbl && two_cycle(w);
        end
        exp_word = w;
        exp_take = take;
        exp_iack = iack_next;
        chk_en   = 1'b1;
    endtask

    task automatic word_in(dsp16_ctrl_pkg::word_t w);
        issue(w, 1'b0, 1'b0, 1'b0, 1'b0);
    endtask

    // if CON, then the branch, then the ignored second half
    task automatic cond_branch(dsp16_ctrl_pkg::word_t w, logic c);
        word_in({5'd26, 1'b0, 10'($urandom)});
        issue(w, c, 1'b0, 1'b0, 1'b0);
        word_in(F1);
    endtask

    task automatic apply_reset();
        @(negedge clk);
        chk_en = 1'b0;
        rst    = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst       = 1'b0;
        dbl       = 1'b0;
        con_pend  = 1'b0;
        exp_iack  = 1'b0;
        exp_fault = 1'b0;
    endtask

    task automatic run_loop(int ni, int k, logic redo);
        int exit_c;
        exit_c = expect_loop(ni, k);
        for (int c = 0; c <= exit_c + 3; c++) begin
            @(negedge clk);
            chk_en = 1'b0;
            if (c == 0)
                rom_dout = redo ? {5'd14, 4'd0, 7'(k)} : {5'd14, 4'(ni), 7'(k)};
            else
                rom_dout = F1;
            #1 check_bit("do_out", c == exit_c, do_out);
        end
        dbl      = 1'b0;
        con_pend = 1'b0;
    endtask

    task automatic end_test(string name, int err_before);
        ntests++;
        if (errors == err_before)
            $display("%s: ok", name);
        else
            $display("%s: %0d errors", name, errors - err_before);
    endtask

    initial begin
        #(TOTAL_WORDS * 8 * 4);
        $display("Watchdog expired before the tests completed");
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        logic [31:0] r;
        int err0, ni, k;
        dsp16_ctrl_pkg::word_t snap_s, snap_f, snap_st, snap_i;
        void'($urandom(32'h8ef2_2f25));
        clk = 1'b0;
        rst = 1'b1;
        cen = 1'b1;
        irq = 1'b0;
        con_result = 1'b0;
        rom_dout = F1;
        chk_en = 1'b0;
        fld_en = 1'b0;
        exp_take = 1'b0;
        exp_fault = 1'b0;
        exp_strobes = '0;
        exp_word = F1;
        errors = 0;
        ntests = 0;
        apply_reset();

        err0 = errors;
        repeat (8) begin
            r = $urandom;
            word_in({4'b0001, r[11:0]});
            word_in({5'd10, r[10], 3'b000, r[6:0]});
            word_in(16'($urandom));            // Long immediate operand
            word_in({3'b010, r[12], 1'b1, r[10:0]});
            word_in(F1);
        end
        end_test("immediate loads and moves", err0);

        err0 = errors;
        repeat (2) begin
            r = $urandom;
            word_in({5'd0, r[10:0]});
            word_in(F1);
            word_in({5'd16, r[10:0]});
            word_in(F1);
            word_in({5'd24, 3'd0, r[7:0]});
            word_in(F1);
            cond_branch({5'd0, r[10:0]}, 1'b0);
            cond_branch({5'd0, r[10:0]}, 1'b1);
            cond_branch({5'd16, r[10:0]}, 1'b0);
            cond_branch({5'd24, 3'd0, r[7:0]}, 1'b0);
            cond_branch({5'd24, 3'd1, r[7:0]}, 1'b0);   // iret ignores the condition
        end
        end_test("branches and conditions", err0);

        err0 = errors;
        repeat (8) begin
            r = $urandom;
            word_in({5'd15, 4'b0000, r[6:0]});
            word_in(F1);
            word_in({5'd12, r[10:0]});
            word_in(F1);
        end
        end_test("ram moves", err0);

        err0 = errors;
        issue(F1, 1'b0, 1'b1, 1'b1, 1'b1);
        issue(F1, 1'b0, 1'b1, 1'b0, 1'b1);
        issue(F1, 1'b0, 1'b1, 1'b0, 1'b1);                  // Blocked by iack
        issue({5'd24, 3'd1, 8'h00}, 1'b0, 1'b1, 1'b0, 1'b1);
        issue(F1, 1'b0, 1'b1, 1'b0, 1'b1);
        issue({5'd26, 1'b1, 10'h0}, 1'b0, 1'b1, 1'b0, 1'b1);
        issue(F1, 1'b0, 1'b1, 1'b0, 1'b0);                  // iack clears here
        issue({5'd26, 1'b1, 10'h0}, 1'b0, 1'b1, 1'b0, 1'b0); // Deferred
        issue(F1, 1'b0, 1'b1, 1'b1, 1'b1);
        issue(F1, 1'b0, 1'b0, 1'b0, 1'b1);
        end_test("interrupts", err0);

        err0 = errors;
        repeat (2) begin
            ni = 2 + int'($urandom % 7);
            k  = 2 + int'($urandom % 9);
            run_loop(ni, k, 1'b0);
            run_loop(ni, k, 1'b1);
        end
        end_test("hardware loops", err0);

        err0 = errors;
        apply_reset();
        check_bit("fault", 1'b0, fault);
        @(negedge clk) rom_dout = {5'd14, 4'd2, 7'd3};
        @(negedge clk) rom_dout = F1;
        @(negedge clk) rom_dout = {5'd0, 11'h0};    // goto inside the loop body
        @(negedge clk) rom_dout = F1;
        check_bit("fault", 1'b1, fault);
        repeat (40) @(negedge clk);
        apply_reset();
        exp_fault = 1'b1;                           // Unknown T field follows
        word_in({5'd31, 11'($urandom)});
        word_in({4'b0001, 12'($urandom)});
        check_bit("fault", 1'b1, fault);
        @(negedge clk);
        chk_en  = 1'b0;
        cen     = 1'b0;
        snap_s  = act_strobes;
        snap_f  = act_fields;
        snap_st = act_status;
        snap_i  = 16'(short_imm);
        rom_dout = F1;      // Interruptible word with irq, taken on any enabled edge
        irq      = 1'b1;
        repeat (6) begin
            @(negedge clk);
            check_word("strobes", snap_s, act_strobes);
            check_word("fields", snap_f, act_fields);
            check_word("status", snap_st, act_status);
            check_word("short_imm", snap_i, 16'(short_imm));
        end
        cen = 1'b1;
        irq = 1'b0;
        end_test("faults and freeze", err0);

        $display("%0d tests run, %0d errors", ntests, errors);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// ==== dsp16_ctrl.f ====
+incdir+tb
source/dsp16_ctrl_pkg.sv
source/loop_if.sv
source/insn_decoder.sv
source/do_loop_seq.sv
source/irq_entry.sv
source/dsp16_ctrl.sv
tb/tb_dsp16_ctrl.sv
